//--- rtl/sdram_pkg.sv
/* sdram controller shared definitions
   geometry, vector types, pin command codes, timing and FSM states */
package sdram_pkg;

  typedef logic [21:0] addr_t;     // {bank[1], row, bank[0], col}
  typedef logic [15:0] data_t;
  typedef logic [1:0]  mask_t;     // active low byte mask
  typedef logic [11:0] row_addr_t; // pin address
  typedef logic [1:0]  bank_t;
  typedef logic [2:0]  wait_cnt_t; // holds the longest wait, T_RFC

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH   = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVATE  = 4'b0011,
    CMD_WRITE     = 4'b0100,
    CMD_READ      = 4'b0101,
    CMD_NOP       = 4'b0111,
    CMD_INHIBIT   = 4'b1111
  } sdram_cmd_t;

  // reserved, write burst mode, op mode, CL 2, sequential, BL 1
  localparam row_addr_t MODE_WORD = {2'b00, 1'b0, 2'b00, 3'd2, 1'b0, 3'd0};

  localparam int CAS_LATENCY    = 2;
  localparam int INIT_REFRESHES = 2;
  localparam int T_RCD = 2;
  localparam int T_RP  = 1;
  localparam int T_RFC = 7;
  localparam int T_MRD = 4;

  typedef enum logic [2:0] {
    INIT_WAIT, INIT_PRECHARGE, INIT_REFRESH, INIT_MODE, INIT_DELAY, INIT_DONE
  } init_state_t;

  typedef enum logic [2:0] {
    SEQ_IDLE, SEQ_ACTIVATE, SEQ_ACCESS, SEQ_PRECHARGE, SEQ_REFRESH, SEQ_WAIT
  } seq_state_t;

endpackage

//--- rtl/sdram_req_if.sv
/* queued host request, from the request FIFO head to the sequencer */
`timescale 1ns/1ps

interface sdram_req_if
  import sdram_pkg::*;
();

  logic  rnw;   // 1 = read
  addr_t addr;
  mask_t dqm;
  data_t wdata;
  logic  empty;
  logic  pop;   // head taken, queue advances on this edge

  modport fifo (output rnw, addr, dqm, wdata, empty, input pop);
  modport seq  (input rnw, addr, dqm, wdata, empty, output pop);

endinterface

//--- rtl/request_fifo.sv
/* two-entry host request queue
   full flag holds off the host, head is presented to the sequencer */
`timescale 1ns/1ps

module request_fifo
  import sdram_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  i_push,
  input  logic  i_rnw,
  input  addr_t i_addr,
  input  mask_t i_dqm,
  input  data_t i_wdata,
  output logic  o_full,
  sdram_req_if.fifo req
);

  logic       rnw_q   [2];
  addr_t      addr_q  [2];
  mask_t      dqm_q   [2];
  data_t      wdata_q [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;

  assign o_full    = (count == 2'd2);
  assign req.empty = (count == 2'd0);
  assign push      = i_push & ~o_full;

  assign req.rnw   = rnw_q[rd_ptr];
  assign req.addr  = addr_q[rd_ptr];
  assign req.dqm   = dqm_q[rd_ptr];
  assign req.wdata = wdata_q[rd_ptr];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr <= ~wr_ptr; // two entries, pointer just toggles
      if (req.pop)
        rd_ptr <= ~rd_ptr;
      if (push && !req.pop)
        count <= count + 2'd1;
      else if (req.pop && !push)
        count <= count - 2'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      rnw_q[wr_ptr]   <= i_rnw;
      addr_q[wr_ptr]  <= i_addr;
      dqm_q[wr_ptr]   <= i_dqm;
      wdata_q[wr_ptr] <= i_wdata;
    end
  end

  // sequencer must only take the head when one is there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
    req.pop |-> !req.empty);

endmodule

//--- rtl/init_refresh.sv
/* power-up wait and init command sequence, then the periodic
   auto-refresh request, all off one shared down-counter */
`timescale 1ns/1ps

module init_refresh
  import sdram_pkg::*;
#(
  parameter int INIT_CYCLES    = 20000,
  parameter int REFRESH_CYCLES = 3125
)
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       i_refresh_ack,
  output logic       o_init_done,
  output sdram_cmd_t o_init_cmd,
  output row_addr_t  o_init_addr,
  output logic       o_refresh_request
);

  localparam int CNT_MAX = (INIT_CYCLES > REFRESH_CYCLES) ? INIT_CYCLES : REFRESH_CYCLES;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  logic [CNT_W-1:0] cnt;
  logic             cnt_zero;
  init_state_t      state;
  init_state_t      next_state;
  wait_cnt_t        wait_cnt;
  logic [1:0]       ref_cnt;

  assign cnt_zero    = (cnt == '0);
  assign o_init_done = (state == INIT_DONE);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      cnt <= CNT_W'(INIT_CYCLES); // power-up wait first
    else if (cnt_zero)
      cnt <= CNT_W'(REFRESH_CYCLES - 1);
    else
      cnt <= cnt - 1'b1;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_refresh_request <= 1'b0;
    else
      o_refresh_request <= ((cnt_zero & o_init_done) | o_refresh_request) & ~i_refresh_ack;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= INIT_WAIT;
      next_state  <= INIT_WAIT;
      wait_cnt    <= '0;
      ref_cnt     <= '0;
      o_init_cmd  <= CMD_INHIBIT;
      o_init_addr <= '0;
    end
    else
    begin
      case (state)
        INIT_WAIT:
        begin
          o_init_cmd <= CMD_INHIBIT;
          if (cnt_zero)
            state <= INIT_PRECHARGE;
        end
        INIT_PRECHARGE:
        begin
          o_init_cmd  <= CMD_PRECHARGE;
          o_init_addr <= 12'h400; // A10 set, all banks
          wait_cnt    <= wait_cnt_t'(T_RP);
          next_state  <= INIT_REFRESH;
          state       <= INIT_DELAY;
        end
        INIT_REFRESH:
        begin
          o_init_cmd <= CMD_REFRESH;
          ref_cnt    <= ref_cnt + 2'd1;
          wait_cnt   <= wait_cnt_t'(T_RFC);
          next_state <= (ref_cnt == 2'(INIT_REFRESHES - 1)) ? INIT_MODE : INIT_REFRESH;
          state      <= INIT_DELAY;
        end
        INIT_MODE:
        begin
          o_init_cmd  <= CMD_LOAD_MODE;
          o_init_addr <= MODE_WORD;
          wait_cnt    <= wait_cnt_t'(T_MRD);
          next_state  <= INIT_DONE;
          state       <= INIT_DELAY;
        end
        INIT_DELAY:
        begin
          o_init_cmd <= CMD_NOP;
          if (wait_cnt > wait_cnt_t'(1))
            wait_cnt <= wait_cnt - 1'b1;
          else
            state <= next_state;
        end
        default: o_init_cmd <= CMD_NOP; // done, sequencer owns the pins
      endcase
    end
  end

  a_refresh_after_init: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(o_refresh_request) |-> o_init_done);

endmodule

//--- rtl/command_sequencer.sv
/* main SDRAM command FSM
   passes init commands through, then runs closed-row accesses and refreshes */
`timescale 1ns/1ps

module command_sequencer
  import sdram_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       i_init_done,
  input  sdram_cmd_t i_init_cmd,
  input  row_addr_t  i_init_addr,
  input  logic       i_refresh_request,
  output logic       o_refresh_ack,
  output sdram_cmd_t o_cmd,
  output row_addr_t  o_addr,
  output bank_t      o_ba,
  output mask_t      o_dqm,
  output data_t      o_wdata,
  output logic       o_dq_oe,
  output logic       o_read_issued,
  sdram_req_if.seq   req
);

  seq_state_t state;
  seq_state_t next_state;
  wait_cnt_t  wait_cnt;
  logic       take;
  logic       act_rnw;
  addr_t      act_addr;
  mask_t      act_dqm;
  data_t      act_wdata;
  bank_t      act_bank;

  // refresh wins over the queue
  assign take     = (state == SEQ_IDLE) & i_init_done & ~i_refresh_request & ~req.empty;
  assign req.pop  = take;
  assign act_bank = {act_addr[21], act_addr[8]};

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      act_rnw   <= req.rnw;
      act_addr  <= req.addr;
      act_dqm   <= req.dqm;
      act_wdata <= req.wdata;
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= SEQ_IDLE;
      next_state    <= SEQ_IDLE;
      wait_cnt      <= '0;
      o_refresh_ack <= 1'b0;
      o_cmd         <= CMD_INHIBIT;
      o_addr        <= '0;
      o_ba          <= '0;
      o_dqm         <= '0;
      o_dq_oe       <= 1'b0;
      o_read_issued <= 1'b0;
    end
    else
    begin
      o_dq_oe       <= 1'b0;
      o_read_issued <= 1'b0;
      case (state)
        SEQ_IDLE:
        begin
          if (!i_init_done)
          begin
            o_cmd  <= i_init_cmd; // init FSM drives the pins
            o_addr <= i_init_addr;
          end
          else if (i_refresh_request)
          begin
            o_cmd      <= CMD_PRECHARGE;
            o_addr     <= 12'h400; // precharge all
            wait_cnt   <= wait_cnt_t'(T_RP);
            next_state <= SEQ_REFRESH;
            state      <= SEQ_WAIT;
          end
          else
          begin
            o_cmd         <= CMD_NOP;
            o_refresh_ack <= 1'b0;
            if (take)
              state <= SEQ_ACTIVATE;
          end
        end
        SEQ_ACTIVATE:
        begin
          o_cmd      <= CMD_ACTIVATE;
          o_ba       <= act_bank;
          o_addr     <= act_addr[20:9];
          wait_cnt   <= wait_cnt_t'(T_RCD);
          next_state <= SEQ_ACCESS;
          state      <= SEQ_WAIT;
        end
        SEQ_ACCESS:
        begin
          o_cmd         <= act_rnw ? CMD_READ : CMD_WRITE;
          o_addr        <= {4'b0000, act_addr[7:0]}; // column, no auto precharge
          o_dqm         <= act_dqm;
          o_dq_oe       <= ~act_rnw;
          o_read_issued <= act_rnw;
          state         <= SEQ_PRECHARGE;
        end
        SEQ_PRECHARGE:
        begin
          o_cmd      <= CMD_PRECHARGE;
          o_addr     <= '0; // A10 low, this bank only
          wait_cnt   <= wait_cnt_t'(T_RP);
          next_state <= SEQ_IDLE;
          state      <= SEQ_WAIT;
        end
        SEQ_REFRESH:
        begin
          o_cmd         <= CMD_REFRESH;
          o_refresh_ack <= 1'b1; // held until back in idle
          wait_cnt      <= wait_cnt_t'(T_RFC);
          next_state    <= SEQ_IDLE;
          state         <= SEQ_WAIT;
        end
        default:
        begin
          o_cmd <= CMD_NOP;
          if (wait_cnt > wait_cnt_t'(1))
            wait_cnt <= wait_cnt - 1'b1;
          else
            state <= next_state;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == SEQ_ACCESS)
      o_wdata <= act_wdata;
  end

  // dq is only driven alongside a write command
  a_oe_with_write: assert property (@(posedge clk) disable iff (!reset_n)
    o_dq_oe |-> (o_cmd == CMD_WRITE));

endmodule

//--- rtl/read_capture.sv
/* read data capture
   tracks reads in flight over the CAS latency and registers the bus */
`timescale 1ns/1ps

module read_capture
  import sdram_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  i_read_issued,
  input  data_t i_dq,
  output data_t o_rdata,
  output logic  o_valid
);

  logic [CAS_LATENCY-1:0] rd_pipe; // one bit per read in flight

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_pipe <= '0;
      o_valid <= 1'b0;
    end
    else
    begin
      rd_pipe <= (rd_pipe << 1) | CAS_LATENCY'(i_read_issued);
      o_valid <= rd_pipe[CAS_LATENCY-1]; // lines up with registered data
    end
  end

  always_ff @(posedge clk)
    o_rdata <= i_dq; // sampled every cycle

endmodule

//--- rtl/sdram_ctrl.sv
/* SDR SDRAM controller top level
   request queue, init/refresh timer, command FSM and read capture */
`timescale 1ns/1ps

module sdram_ctrl
  import sdram_pkg::*;
#(
  parameter int INIT_CYCLES    = 20000,
  parameter int REFRESH_CYCLES = 3125
)
(
  input  logic      clk,
  input  logic      reset_n,
  input  addr_t     i_addr,
  input  mask_t     i_be_n,
  input  data_t     i_wdata,
  input  logic      i_rd_n,
  input  logic      i_wr_n,
  output logic      o_waitrequest,
  output data_t     o_rdata,
  output logic      o_valid,
  output row_addr_t o_sdram_addr,
  output bank_t     o_sdram_ba,
  output logic      o_sdram_cs_n,
  output logic      o_sdram_ras_n,
  output logic      o_sdram_cas_n,
  output logic      o_sdram_we_n,
  output mask_t     o_sdram_dqm,
  output logic      o_sdram_cke,
  inout  data_t     io_sdram_dq
);

  sdram_req_if req_if ();

  logic       init_done;
  sdram_cmd_t init_cmd;
  row_addr_t  init_addr;
  logic       refresh_request;
  logic       refresh_ack;
  sdram_cmd_t seq_cmd;
  data_t      seq_wdata;
  logic       dq_oe;
  logic       read_issued;

  assign {o_sdram_cs_n, o_sdram_ras_n, o_sdram_cas_n, o_sdram_we_n} = seq_cmd;
  assign o_sdram_cke = 1'b1;
  assign io_sdram_dq = dq_oe ? seq_wdata : 'z;

  request_fifo u_request_fifo (
    .clk     (clk),
    .reset_n (reset_n),
    .i_push  (~i_rd_n | ~i_wr_n),
    .i_rnw   (i_wr_n),
    .i_addr  (i_addr),
    .i_dqm   (i_wr_n ? 2'b00 : i_be_n), // reads get all bytes
    .i_wdata (i_wdata),
    .o_full  (o_waitrequest),
    .req     (req_if.fifo)
  );

  init_refresh #(
    .INIT_CYCLES    (INIT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_init_refresh (
    .clk               (clk),
    .reset_n           (reset_n),
    .i_refresh_ack     (refresh_ack),
    .o_init_done       (init_done),
    .o_init_cmd        (init_cmd),
    .o_init_addr       (init_addr),
    .o_refresh_request (refresh_request)
  );

  command_sequencer u_command_sequencer (
    .clk               (clk),
    .reset_n           (reset_n),
    .i_init_done       (init_done),
    .i_init_cmd        (init_cmd),
    .i_init_addr       (init_addr),
    .i_refresh_request (refresh_request),
    .o_refresh_ack     (refresh_ack),
    .o_cmd             (seq_cmd),
    .o_addr            (o_sdram_addr),
    .o_ba              (o_sdram_ba),
    .o_dqm             (o_sdram_dqm),
    .o_wdata           (seq_wdata),
    .o_dq_oe           (dq_oe),
    .o_read_issued     (read_issued),
    .req               (req_if.seq)
  );

  read_capture u_read_capture (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_read_issued (read_issued),
    .i_dq          (io_sdram_dq),
    .o_rdata       (o_rdata),
    .o_valid       (o_valid)
  );

endmodule

//--- testbench/sdram_model.sv
/* behavioural SDR SDRAM for the controller testbench
   decodes pin commands, stores masked writes, returns reads after the CAS latency */
`timescale 1ns/1ps

module sdram_model
  import sdram_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  row_addr_t i_addr,
  input  bank_t     i_ba,
  input  logic      i_cs_n,
  input  logic      i_ras_n,
  input  logic      i_cas_n,
  input  logic      i_we_n,
  input  mask_t     i_dqm,
  inout  wire [15:0] io_dq,
  output logic      o_err_closed_bank,
  output logic      o_err_open_bank,
  output logic      o_err_refresh_open
);

  data_t                  mem [addr_t];  // sparse, keyed by host word address
  logic [3:0]             bank_open;
  row_addr_t              open_row [4];
  logic [CAS_LATENCY-1:0] rd_pipe;       // reads on their way to the bus
  data_t                  rd_data [CAS_LATENCY];
  sdram_cmd_t             cmd;
  addr_t                  word_addr;
  data_t                  wr_word;
  sdram_cmd_t             cmd_log [8];   // first commands other than nop and inhibit
  row_addr_t              addr_log [8];
  int                     log_count;

  assign cmd       = sdram_cmd_t'({i_cs_n, i_ras_n, i_cas_n, i_we_n});
  assign word_addr = {i_ba[1], open_row[i_ba], i_ba[0], i_addr[7:0]};
  assign io_dq     = rd_pipe[CAS_LATENCY-1] ? rd_data[CAS_LATENCY-1] : 'z;

  always @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      bank_open          <= '0;
      rd_pipe            <= '0;
      log_count          <= 0;
      o_err_closed_bank  <= 1'b0;
      o_err_open_bank    <= 1'b0;
      o_err_refresh_open <= 1'b0;
    end
    else
    begin
      rd_pipe    <= {rd_pipe[CAS_LATENCY-2:0], cmd == CMD_READ};
      rd_data[0] <= mem[word_addr];
      for (int i = 1; i < CAS_LATENCY; i++)
        rd_data[i] <= rd_data[i-1];
      if (cmd != CMD_NOP && cmd != CMD_INHIBIT && log_count < 8)
      begin
        cmd_log[log_count]  <= cmd;
        addr_log[log_count] <= i_addr;
        log_count           <= log_count + 1;
      end
      if ((cmd == CMD_READ || cmd == CMD_WRITE) && !bank_open[i_ba])
        o_err_closed_bank <= 1'b1;
      case (cmd)
        CMD_ACTIVATE:
        begin
          if (bank_open[i_ba])
            o_err_open_bank <= 1'b1;
          bank_open[i_ba] <= 1'b1;
          open_row[i_ba]  <= i_addr;
        end
        CMD_PRECHARGE:
        begin
          if (i_addr[10])
            bank_open <= '0; // all banks
          else
            bank_open[i_ba] <= 1'b0;
        end
        CMD_REFRESH:
        begin
          if (bank_open != '0)
            o_err_refresh_open <= 1'b1;
        end
        CMD_WRITE:
        begin
          wr_word = mem.exists(word_addr) ? mem[word_addr] : '0;
          for (int b = 0; b < 2; b++)
            if (!i_dqm[b])
              wr_word[8*b +: 8] = io_dq[8*b +: 8]; // dqm high masks the byte
          mem[word_addr] = wr_word;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- testbench/tb_sdram_ctrl.sv
/* testbench for the SDRAM controller
   random host traffic over a small address pool, checked against a reference memory */
`timescale 1ns/1ps

module tb_sdram_ctrl;
  import sdram_pkg::*;

  localparam int INIT_CYCLES    = 200;
  localparam int REFRESH_CYCLES = 400;
  localparam int CLK_PERIOD     = 10;
  localparam int NUM_ADDR       = 16;
  localparam int NUM_REQ        = 300;
  localparam int REFRESH_LIMIT  = REFRESH_CYCLES + 20;
  localparam int TIMEOUT_CYCLES = INIT_CYCLES + (NUM_ADDR + NUM_REQ) * 40;

  logic       clk;
  logic       reset_n;
  addr_t      i_addr;
  mask_t      i_be_n;
  data_t      i_wdata;
  logic       i_rd_n;
  logic       i_wr_n;
  logic       o_waitrequest;
  data_t      o_rdata;
  logic       o_valid;
  row_addr_t  sdram_addr;
  bank_t      sdram_ba;
  logic       sdram_cs_n;
  logic       sdram_ras_n;
  logic       sdram_cas_n;
  logic       sdram_we_n;
  mask_t      sdram_dqm;
  logic       sdram_cke;
  wire [15:0] sdram_dq;
  logic       err_closed_bank;
  logic       err_open_bank;
  logic       err_refresh_open;
  sdram_cmd_t pin_cmd;

  int    seed;
  addr_t addr_pool [NUM_ADDR];
  data_t ref_mem   [NUM_ADDR];
  data_t exp_q     [$];       // read data in request order
  int    rd_stamp_q [$];      // cycle of each read command on the pins
  int    cycle           = 0;
  int    reads_accepted  = 0;
  int    writes_accepted = 0;
  int    reads_on_pins   = 0;
  int    writes_on_pins  = 0;
  int    reads_returned  = 0;
  int    refresh_count   = 0;
  int    init_cycle      = 0;
  int    last_refresh    = 0;
  logic  init_seen       = 1'b0;

  assign pin_cmd = sdram_cmd_t'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});

  sdram_ctrl #(
    .INIT_CYCLES    (INIT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_addr        (i_addr),
    .i_be_n        (i_be_n),
    .i_wdata       (i_wdata),
    .i_rd_n        (i_rd_n),
    .i_wr_n        (i_wr_n),
    .o_waitrequest (o_waitrequest),
    .o_rdata       (o_rdata),
    .o_valid       (o_valid),
    .o_sdram_addr  (sdram_addr),
    .o_sdram_ba    (sdram_ba),
    .o_sdram_cs_n  (sdram_cs_n),
    .o_sdram_ras_n (sdram_ras_n),
    .o_sdram_cas_n (sdram_cas_n),
    .o_sdram_we_n  (sdram_we_n),
    .o_sdram_dqm   (sdram_dqm),
    .o_sdram_cke   (sdram_cke),
    .io_sdram_dq   (sdram_dq)
  );

  sdram_model u_sdram_model (
    .clk                (clk),
    .reset_n            (reset_n),
    .i_addr             (sdram_addr),
    .i_ba               (sdram_ba),
    .i_cs_n             (sdram_cs_n),
    .i_ras_n            (sdram_ras_n),
    .i_cas_n            (sdram_cas_n),
    .i_we_n             (sdram_we_n),
    .i_dqm              (sdram_dqm),
    .io_dq              (sdram_dq),
    .o_err_closed_bank  (err_closed_bank),
    .o_err_open_bank    (err_open_bank),
    .o_err_refresh_open (err_refresh_open)
  );

  task automatic stop_with_errors();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic fail_value(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
    $display("Fail %s: expected %0h actual %0h", test, expected, actual);
    stop_with_errors();
  endtask

  task automatic fail_plain(input string what);
    $display("Error: %s", what);
    stop_with_errors();
  endtask

  // called on a falling edge, returns on a falling edge with the strobes released
  task automatic send_request(input logic is_read, input int idx, input mask_t be_n,
                              input data_t wdata);
    i_addr  = addr_pool[idx];
    i_be_n  = be_n;
    i_wdata = wdata;
    i_rd_n  = ~is_read;
    i_wr_n  = is_read;
    while (o_waitrequest)
      @(negedge clk);
    // taken at the coming rising edge
    if (is_read)
    begin
      exp_q.push_back(ref_mem[idx]);
      reads_accepted++;
    end
    else
    begin
      for (int b = 0; b < 2; b++)
        if (!be_n[b])
          ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
      writes_accepted++;
    end
    @(negedge clk);
    i_rd_n = 1'b1;
    i_wr_n = 1'b1;
  endtask

  task automatic check_read_return();
    data_t expected;
    int    stamp;
    assert (exp_q.size() > 0 && rd_stamp_q.size() > 0)
      else fail_plain("o_valid pulsed with no read outstanding");
    expected = exp_q.pop_front();
    stamp    = rd_stamp_q.pop_front();
    reads_returned++;
    assert (cycle - stamp == CAS_LATENCY + 1)
      else fail_value("read_latency", CAS_LATENCY + 1, cycle - stamp);
    assert (o_rdata === expected)
      else fail_value("write_read_data", expected, o_rdata);
  endtask

  task automatic check_init_sequence();
    assert (init_seen && u_sdram_model.log_count >= 4)
      else fail_plain("init_sequence: the init commands never all appeared");
    assert (u_sdram_model.cmd_log[0] == CMD_PRECHARGE)
      else fail_value("init_sequence", CMD_PRECHARGE, u_sdram_model.cmd_log[0]);
    assert (u_sdram_model.addr_log[0][10])
      else fail_plain("init_sequence: first precharge does not address all banks");
    for (int i = 1; i <= 2; i++)
      assert (u_sdram_model.cmd_log[i] == CMD_REFRESH)
        else fail_value("init_sequence", CMD_REFRESH, u_sdram_model.cmd_log[i]);
    assert (u_sdram_model.cmd_log[3] == CMD_LOAD_MODE)
      else fail_value("init_sequence", CMD_LOAD_MODE, u_sdram_model.cmd_log[3]);
    // CL 2 in A6..A4, sequential, burst length 1
    assert (u_sdram_model.addr_log[3] == 12'h020)
      else fail_value("init_sequence", 12'h020, u_sdram_model.addr_log[3]);
  endtask

  task automatic check_final_counts();
    assert (reads_returned == reads_accepted)
      else fail_value("command_legality", reads_accepted, reads_returned);
    assert (reads_on_pins == reads_accepted)
      else fail_value("command_legality", reads_accepted, reads_on_pins);
    assert (writes_on_pins == writes_accepted)
      else fail_value("command_legality", writes_accepted, writes_on_pins);
    assert (cycle - last_refresh <= REFRESH_LIMIT)
      else fail_value("refresh_interval", REFRESH_LIMIT, cycle - last_refresh);
    assert (refresh_count >= (cycle - init_cycle) / REFRESH_CYCLES)
      else fail_value("refresh_interval", (cycle - init_cycle) / REFRESH_CYCLES, refresh_count);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // pin and host-side monitor
  always @(posedge clk)
  begin
    if (reset_n)
    begin
      cycle = cycle + 1;
      assert (sdram_cke === 1'b1)
        else fail_value("cke_high", 1'b1, sdram_cke);
      assert (!err_closed_bank)
        else fail_plain("command_legality: read or write to a bank with no open row");
      assert (!err_open_bank)
        else fail_plain("command_legality: activate to a bank that is already open");
      assert (!err_refresh_open)
        else fail_plain("command_legality: auto refresh with a bank still open");
      case (pin_cmd)
        CMD_READ:
        begin
          rd_stamp_q.push_back(cycle);
          reads_on_pins++;
        end
        CMD_WRITE: writes_on_pins++;
        CMD_LOAD_MODE:
        begin
          init_seen    = 1'b1;
          init_cycle   = cycle;
          last_refresh = cycle; // periodic refresh timing counts from here
        end
        CMD_REFRESH:
        begin
          if (init_seen)
          begin
            assert (cycle - last_refresh <= REFRESH_LIMIT)
              else fail_value("refresh_interval", REFRESH_LIMIT, cycle - last_refresh);
            last_refresh = cycle;
            refresh_count++;
          end
        end
        default: ;
      endcase
      if (o_valid)
        check_read_return();
    end
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    fail_plain("timeout: the requests did not complete in time");
  end

  initial
  begin
    int   idx;
    logic is_read;
    seed    = 32'h7466;
    reset_n = 1'b0;
    i_addr  = '0;
    i_be_n  = 2'b11;
    i_wdata = '0;
    i_rd_n  = 1'b1;
    i_wr_n  = 1'b1;
    // distinct pool, low column bits carry the index
    for (int i = 0; i < NUM_ADDR; i++)
    begin
      addr_pool[i]      = addr_t'($random(seed));
      addr_pool[i][3:0] = 4'(i);
    end
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    for (int i = 0; i < NUM_ADDR; i++)
      send_request(1'b0, i, 2'b00, data_t'($random(seed))); // known contents first
    for (int n = 0; n < NUM_REQ; n++)
    begin
      idx     = $unsigned($random(seed)) % NUM_ADDR;
      is_read = 1'($random(seed));
      send_request(is_read, idx, mask_t'($random(seed)), data_t'($random(seed)));
      repeat ($unsigned($random(seed)) % 3)
        @(negedge clk);
    end
    // every accepted request has reached the pins
    while (reads_on_pins + writes_on_pins < reads_accepted + writes_accepted)
      @(negedge clk);
    repeat (CAS_LATENCY + 1) @(negedge clk); // last read data back on the host side
    check_init_sequence();
    check_final_counts();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- sources.f
rtl/sdram_pkg.sv
rtl/sdram_req_if.sv
rtl/request_fifo.sv
rtl/init_refresh.sv
rtl/command_sequencer.sv
rtl/read_capture.sv
rtl/sdram_ctrl.sv
testbench/sdram_model.sv
testbench/tb_sdram_ctrl.sv

//--- Bender.yml
package:
  name: sdram_ctrl

sources:
  - rtl/sdram_pkg.sv
  - rtl/sdram_req_if.sv
  - rtl/request_fifo.sv
  - rtl/init_refresh.sv
  - rtl/command_sequencer.sv
  - rtl/read_capture.sv
  - rtl/sdram_ctrl.sv
  - target: test
    files:
      - testbench/sdram_model.sv
      - testbench/tb_sdram_ctrl.sv
